// ==== Makefile ====
SOURCES = sim.f \
	source/crc_pkg.sv \
	source/host_interface.sv \
	source/crc_data_buffer.sv \
	source/crc_engine.sv \
	source/crc_ahb_top.sv \
	dv/crc_tb_sva.sv \
	dv/crc_tb.sv

.PHONY: run clean

run: obj_dir/crc_tb
	@out=$$(./obj_dir/crc_tb); echo "$$out"; echo "$$out" | grep -q "All checks passed"

obj_dir/crc_tb: $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ns -Mdir obj_dir -o crc_tb \
		--top-module crc_tb -f sim.f

clean:
	rm -rf obj_dir

// ==== dv/crc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_tb;

	// Up to 200 transfers of at most 20 cycles each
	localparam int MAX_CYCLES = 200 * 20;

	// Reset values of the default top level
	localparam logic [31:0] DEF_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] DEF_POLY = 32'h04C1_1DB7;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Reference model state
	logic [31:0] m_init;
	logic [31:0] m_poly;
	logic [7:0]  m_idr;
	logic [7:0]  m_cr;
	logic [31:0] m_crc;

	integer      seed;
	int          cycle_count = 0;
	int          error_count = 0;
	logic [31:0] rd_data;
	logic [31:0] rnd;
	logic [1:0]  sz;

	crc_ahb_top crc_ahb_top_i
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	bind crc_ahb_top crc_tb_sva crc_tb_sva_i
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HREADY    (HREADY),
		.HREADYOUT (HREADYOUT)
	);

	initial
		HCLK = 1'b0;

	always #50 HCLK = ~HCLK;

	// Watchdog on total run length
	always @(posedge HCLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Checks failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			error_count++;
			$display("** Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic check_resp(input logic got, input string what);
		if (got !== 1'b0)
		begin
			error_count++;
			$display("** Error at %0t ns: %s is not OKAY", $time, what);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	// Address phase, bus goes back to IDLE once it is taken
	task automatic drive_addr(input logic [2:0] offset, input logic [1:0] size, input logic write);
		HSElx  = 1'b1;
		HADDR  = {27'h0, offset, 2'b00};
		HTRANS = crc_pkg::HTRANS_NONSEQ;
		HSIZE  = {1'b0, size};
		HWRITE = write;
		@(posedge HCLK);
		#10;
		HSElx  = 1'b0;
		HTRANS = crc_pkg::HTRANS_IDLE;
		HWRITE = 1'b0;
	endtask

	// Mid-cycle sampling, outputs are settled there
	task automatic finish_data();
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		rd_data = HRDATA;
		check_resp(HRESP, "HRESP");
		@(posedge HCLK);
		#10;
	endtask

	task automatic bus_write(input logic [2:0] offset, input logic [1:0] size,
		input logic [31:0] data);
		drive_addr(offset, size, 1'b1);
		HWDATA = data;
		finish_data();
	endtask

	task automatic bus_read(input logic [2:0] offset);
		drive_addr(offset, crc_pkg::SIZE_WORD, 1'b0);
		HWDATA = $random(seed);
		finish_data();
	endtask

	// Zero to three IDLE cycles
	task automatic idle_gap();
		int n;
		n = $random(seed) & 3;
		repeat (n)
		begin
			@(posedge HCLK);
			#10;
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic int poly_width(input logic [1:0] code);
		case (code)
			crc_pkg::POLY_32: return 32;
			crc_pkg::POLY_16: return 16;
			crc_pkg::POLY_8:  return 8;
			default:          return 7;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(input int width);
		if (width == 32)
			return 32'hFFFF_FFFF;
		else
			return (32'h1 << width) - 32'h1;
	endfunction

	// Whole-word reverse, then put the groups back in order
	function automatic logic [31:0] reverse_in_units(input logic [31:0] d, input int unit_bytes);
		logic [31:0] full;
		logic [31:0] r;
		full = {<<{d}};
		if (unit_bytes == 1)
			r = {<<8{full}};
		else if (unit_bytes == 2)
			r = {<<16{full}};
		else
			r = full;
		return r;
	endfunction

	// Serial CRC, one byte MSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
		int          width;
		logic [31:0] mask;
		logic        fb;
		width = poly_width(m_cr[4:3]);
		mask  = width_mask(width);
		for (int i = 7; i >= 0; i--)
		begin
			fb  = crc[width - 1] ^ b[i];
			crc = (crc << 1) & mask;
			if (fb)
				crc = crc ^ (m_poly & mask);
		end
		return crc;
	endfunction

	task automatic model_dr(input logic [1:0] size, input logic [31:0] data);
		crc_pkg::crc_dr_word_u w;
		int nbytes;
		int rev_bytes;
		case (size)
			crc_pkg::SIZE_BYTE: nbytes = 1;
			crc_pkg::SIZE_HALF: nbytes = 2;
			default:            nbytes = 4;
		endcase
		case (m_cr[6:5])
			crc_pkg::REV_BYTE: rev_bytes = 1;
			crc_pkg::REV_HALF: rev_bytes = 2;
			crc_pkg::REV_WORD: rev_bytes = 4;
			default:           rev_bytes = 0;
		endcase
		// Only the low lanes carry data
		if (nbytes == 1)
			w.word = {24'h0, data[7:0]};
		else if (nbytes == 2)
			w.word = {16'h0, data[15:0]};
		else
			w.word = data;
		if (rev_bytes != 0)
			w.word = reverse_in_units(w.word, (rev_bytes < nbytes) ? rev_bytes : nbytes);
		// Top valid byte goes in first
		for (int k = nbytes - 1; k >= 0; k--)
			m_crc = crc_byte(m_crc, w.bytes[k]);
	endtask

	function automatic logic [31:0] expected_dr();
		logic [31:0] v;
		logic [31:0] r;
		v = m_crc & width_mask(poly_width(m_cr[4:3]));
		r = {<<{v}};
		return m_cr[7] ? r : v;
	endfunction

	// Bus write plus the matching model update
	task automatic write_reg(input logic [2:0] offset, input logic [1:0] size,
		input logic [31:0] data);
		bus_write(offset, size, data);
		case (offset)
			crc_pkg::CRC_DR:   model_dr(size, data);
			crc_pkg::CRC_IDR:  m_idr = data[7:0];
			crc_pkg::CRC_CR:
			begin
				m_cr = {data[7:3], 3'b000};
				// Restart sees the INIT value of this moment
				if (data[0])
					m_crc = m_init;
			end
			crc_pkg::CRC_INIT: m_init = data;
			crc_pkg::CRC_POL:  m_poly = data;
			default: ;
		endcase
	endtask

	task automatic read_check(input logic [2:0] offset, input logic [31:0] exp, input string what);
		bus_read(offset);
		check_data(rd_data, exp, what);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		seed    = 32'ha3cf_d99c;
		HRESETn = 1'b0;
		HSElx   = 1'b0;
		HADDR   = 32'h0;
		HTRANS  = crc_pkg::HTRANS_IDLE;
		HSIZE   = 3'h0;
		HWRITE  = 1'b0;
		HWDATA  = 32'h0;
		HREADY  = 1'b1;
		m_init  = DEF_INIT;
		m_poly  = DEF_POLY;
		m_idr   = 8'h00;
		m_cr    = 8'h00;
		m_crc   = DEF_INIT;
		repeat (5) @(posedge HCLK);
		#10;
		HRESETn = 1'b1;

		// Reset values
		read_check(crc_pkg::CRC_INIT, m_init, "INIT after reset");
		read_check(crc_pkg::CRC_POL, m_poly, "POLY after reset");
		read_check(crc_pkg::CRC_CR, {24'h0, m_cr}, "CR after reset");
		read_check(crc_pkg::CRC_IDR, {24'h0, m_idr}, "IDR after reset");
		read_check(crc_pkg::CRC_DR, expected_dr(), "DR after reset");

		// Register write and read back
		for (int r = 0; r < 2; r++)
		begin
			write_reg(crc_pkg::CRC_POL, crc_pkg::SIZE_WORD, $random(seed));
			write_reg(crc_pkg::CRC_INIT, crc_pkg::SIZE_WORD, $random(seed));
			write_reg(crc_pkg::CRC_IDR, crc_pkg::SIZE_WORD, $random(seed));
			write_reg(crc_pkg::CRC_CR, crc_pkg::SIZE_WORD, $random(seed));
			read_check(crc_pkg::CRC_POL, m_poly, "POLY read back");
			read_check(crc_pkg::CRC_INIT, m_init, "INIT read back");
			read_check(crc_pkg::CRC_IDR, {24'h0, m_idr}, "IDR read back");
			read_check(crc_pkg::CRC_CR, {24'h0, m_cr}, "CR read back");
		end

		// Every poly size against every input reversal
		for (int g = 0; g < 16; g++)
		begin
			write_reg(crc_pkg::CRC_POL, crc_pkg::SIZE_WORD, $random(seed));
			write_reg(crc_pkg::CRC_INIT, crc_pkg::SIZE_WORD, $random(seed));
			rnd = $random(seed);
			write_reg(crc_pkg::CRC_CR, crc_pkg::SIZE_WORD,
				{24'h0, rnd[0], g[3:2], g[1:0], 2'b00, 1'b1});
			repeat (1 + (rnd[3:2]))
			begin
				idle_gap();
				rnd = $random(seed);
				sz  = (rnd[1:0] == 2'd3) ? crc_pkg::SIZE_WORD : rnd[1:0];
				write_reg(crc_pkg::CRC_DR, sz, $random(seed));
			end
			idle_gap();
			read_check(crc_pkg::CRC_DR, expected_dr(), "DR after data");
		end

		// Restart while words are still in the buffer and engine
		write_reg(crc_pkg::CRC_CR, crc_pkg::SIZE_WORD, 32'h0000_0001);
		for (int k = 0; k < 3; k++)
			write_reg(crc_pkg::CRC_DR, crc_pkg::SIZE_WORD, $random(seed));
		write_reg(crc_pkg::CRC_CR, crc_pkg::SIZE_WORD, 32'h0000_0001);
		// INIT write lands only after the pending load
		write_reg(crc_pkg::CRC_INIT, crc_pkg::SIZE_WORD, $random(seed));
		for (int k = 0; k < 2; k++)
			write_reg(crc_pkg::CRC_DR, crc_pkg::SIZE_WORD, $random(seed));
		read_check(crc_pkg::CRC_DR, expected_dr(), "DR after restart");
		read_check(crc_pkg::CRC_INIT, m_init, "INIT after restart");
		write_reg(crc_pkg::CRC_CR, crc_pkg::SIZE_WORD, 32'h0000_0001);
		read_check(crc_pkg::CRC_DR, expected_dr(), "DR after second restart");

		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/crc_tb_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_tb_sva
(
	input wire logic        HCLK,
	input wire logic        HRESETn,
	input wire logic        HSElx,
	input wire logic [31:0] HADDR,
	input wire logic [1:0]  HTRANS,
	input wire logic        HWRITE,
	input wire logic        HREADY,
	input wire logic        HREADYOUT
);

	logic bus_sampled;
	logic nonseq_sel;
	logic stall_target;

	// Address phase accepted by the slave
	assign bus_sampled = HREADY && HREADYOUT;
	assign nonseq_sel  = HSElx && (HTRANS == crc_pkg::HTRANS_NONSEQ);

	// Only DR accesses and INIT writes may stretch a data phase
	assign stall_target = (HADDR[4:2] == crc_pkg::CRC_DR) ||
	                      (HWRITE && (HADDR[4:2] == crc_pkg::CRC_INIT));

	// Ready straight out of reset
	a_ready_after_reset: assert property (@(posedge HCLK) !HRESETn |=> HREADYOUT)
		else $error("HREADYOUT low in the cycle after reset");

	// No wait state after an idle or unselected address phase
	a_ready_when_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(bus_sampled && !nonseq_sel) |=> HREADYOUT)
		else $error("Wait state without an active transfer");

	// IDR, CR, POLY and INIT reads always complete at once
	a_ready_plain_regs: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(bus_sampled && nonseq_sel && !stall_target) |=> HREADYOUT)
		else $error("Wait state on a register that never stalls");

endmodule

`default_nettype wire

// ==== sim.f ====
source/crc_pkg.sv
source/host_interface.sv
source/crc_data_buffer.sv
source/crc_engine.sv
source/crc_ahb_top.sv
dv/crc_tb_sva.sv
dv/crc_tb.sv

// ==== source/crc_ahb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_ahb_top
#(
	parameter logic [31:0] RESET_INIT = 32'hFFFF_FFFF,
	parameter logic [31:0] RESET_POLY = 32'h04C1_1DB7
)
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        HSElx,
	input  wire logic [31:0] HADDR,
	input  wire logic [1:0]  HTRANS,
	input  wire logic [2:0]  HSIZE,
	input  wire logic        HWRITE,
	input  wire logic [31:0] HWDATA,
	input  wire logic        HREADY,
	output logic      [31:0] HRDATA,
	output logic             HREADYOUT,
	output logic             HRESP
);

	// Host to buffer
	logic [31:0] bus_wr;
	logic [1:0]  bus_size;
	logic [1:0]  rev_in_type;
	logic        buffer_write_en;
	logic        buffer_full;

	// Host to engine
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        reset_chain;
	logic [1:0]  crc_poly_size;
	logic        rev_out_type;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        reset_pending;
	logic        read_wait;

	// Buffer to engine
	crc_pkg::crc_dr_word_u buffer_data;
	logic [1:0]  buffer_count;
	logic        buffer_take;

	host_interface host_interface_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.rev_in_type     (rev_in_type),
		.rev_out_type    (rev_out_type),
		.crc_poly_size   (crc_poly_size),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.reset_chain     (reset_chain)
	);

	crc_data_buffer crc_data_buffer_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.rev_in_type     (rev_in_type),
		.buffer_write_en (buffer_write_en),
		.buffer_take     (buffer_take),
		.buffer_data     (buffer_data),
		.buffer_count    (buffer_count),
		.buffer_full     (buffer_full)
	);

	crc_engine
	#(
		.RESET_INIT (RESET_INIT),
		.RESET_POLY (RESET_POLY)
	)
	crc_engine_i
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.bus_wr        (bus_wr),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.crc_idr_en    (crc_idr_en),
		.reset_chain   (reset_chain),
		.crc_poly_size (crc_poly_size),
		.rev_out_type  (rev_out_type),
		.buffer_data   (buffer_data),
		.buffer_count  (buffer_count),
		.buffer_full   (buffer_full),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out),
		.buffer_take   (buffer_take),
		.reset_pending (reset_pending),
		.read_wait     (read_wait)
	);

endmodule

`default_nettype wire

// ==== source/crc_data_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_data_buffer
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic [31:0] bus_wr,
	input  wire logic [1:0]  bus_size,
	input  wire logic [1:0]  rev_in_type,
	input  wire logic        buffer_write_en,
	input  wire logic        buffer_take,
	output crc_pkg::crc_dr_word_u buffer_data,
	output logic      [1:0]  buffer_count,
	output logic             buffer_full
);

	// Low lanes of the write, upper lanes cleared
	logic [31:0] lane_data;

	// Candidate reversals at each unit width
	logic [31:0] rev_byte;
	logic [31:0] rev_half;
	logic [31:0] rev_word;
	logic [31:0] rev_data;

	// Effective reversal unit, in size encoding
	logic [1:0] rev_unit;
	logic [1:0] byte_count;

	always_comb
	begin
		unique case (bus_size)
			crc_pkg::SIZE_BYTE: lane_data = {24'h0, bus_wr[7:0]};
			crc_pkg::SIZE_HALF: lane_data = {16'h0, bus_wr[15:0]};
			default:            lane_data = bus_wr;
		endcase
	end

	// Bit swaps inside each byte, halfword and the word
	for (genvar i = 0; i < 32; i++)
	begin : g_rev
		assign rev_byte[i] = lane_data[(i / 8) * 8 + 7 - (i % 8)];
		assign rev_half[i] = lane_data[(i / 16) * 16 + 15 - (i % 16)];
		assign rev_word[i] = lane_data[31 - i];
	end

	// Unit is the smaller of reversal width and transfer width
	always_comb
	begin
		rev_unit = rev_in_type - 2'd1;
		if (bus_size < rev_unit)
			rev_unit = bus_size;
	end

	// Empty lanes stay zero since the unit never exceeds the transfer
	always_comb
	begin
		if (rev_in_type == crc_pkg::REV_NONE)
			rev_data = lane_data;
		else
		begin
			unique case (rev_unit)
				crc_pkg::SIZE_BYTE: rev_data = rev_byte;
				crc_pkg::SIZE_HALF: rev_data = rev_half;
				default:            rev_data = rev_word;
			endcase
		end
	end

	// Index of the top valid byte
	always_comb
	begin
		unique case (bus_size)
			crc_pkg::SIZE_BYTE: byte_count = 2'd0;
			crc_pkg::SIZE_HALF: byte_count = 2'd1;
			default:            byte_count = 2'd3;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			buffer_data.word <= rev_data;
			buffer_count     <= byte_count;
		end
	end

	// Write never coincides with take, host stalls writes while full
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			buffer_full <= 1'b0;
		else if (buffer_write_en)
			buffer_full <= 1'b1;
		else if (buffer_take)
			buffer_full <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== source/crc_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module crc_engine
#(
	parameter logic [31:0] RESET_INIT = 32'hFFFF_FFFF,
	parameter logic [31:0] RESET_POLY = 32'h04C1_1DB7
)
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic [31:0] bus_wr,
	input  wire logic        crc_init_en,
	input  wire logic        crc_poly_en,
	input  wire logic        crc_idr_en,
	input  wire logic        reset_chain,
	input  wire logic [1:0]  crc_poly_size,
	input  wire logic        rev_out_type,
	input  wire crc_pkg::crc_dr_word_u buffer_data,
	input  wire logic [1:0]  buffer_count,
	input  wire logic        buffer_full,
	output logic      [31:0] crc_out,
	output logic      [31:0] crc_init_out,
	output logic      [31:0] crc_poly_out,
	output logic      [7:0]  crc_idr_out,
	output logic             buffer_take,
	output logic             reset_pending,
	output logic             read_wait
);

	logic [31:0] crc_ff;
	logic [31:0] crc_next;
	logic [31:0] crc_masked;
	logic [31:0] crc_rev;

	// Word being fed and the byte currently on the input
	crc_pkg::crc_dr_word_u work_word;
	logic [1:0] byte_idx;
	logic       busy;
	logic       can_load;

	// Width mask and top bit for the chosen polynomial size
	logic [31:0] width_mask;
	logic [4:0]  top_bit;

	always_comb
	begin
		unique case (crc_poly_size)
			crc_pkg::POLY_32: begin width_mask = 32'hFFFF_FFFF; top_bit = 5'd31; end
			crc_pkg::POLY_16: begin width_mask = 32'h0000_FFFF; top_bit = 5'd15; end
			crc_pkg::POLY_8:  begin width_mask = 32'h0000_00FF; top_bit = 5'd7;  end
			default:          begin width_mask = 32'h0000_007F; top_bit = 5'd6;  end
		endcase
	end

	// One byte through the serial LFSR, MSB first
	always_comb
	begin
		crc_next = crc_ff;
		for (int i = 7; i >= 0; i--)
		begin
			if (crc_next[top_bit] ^ work_word.bytes[byte_idx][i])
				crc_next = ((crc_next << 1) & width_mask) ^ (crc_poly_out & width_mask);
			else
				crc_next = (crc_next << 1) & width_mask;
		end
	end

	////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_init_out <= RESET_INIT;
			crc_poly_out <= RESET_POLY;
			crc_idr_out  <= 8'h00;
		end
		else
		begin
			if (crc_init_en)
				crc_init_out <= bus_wr;
			if (crc_poly_en)
				crc_poly_out <= bus_wr;
			if (crc_idr_en)
				crc_idr_out <= bus_wr[7:0];
		end
	end

	////////////////////////////////////////
	// Byte sequencer and CRC state
	////////////////////////////////////////

	// Idle engine pulls the buffered word
	assign buffer_take = buffer_full && !busy;

	// Restart waits until nothing is in flight
	assign can_load = !buffer_full && !busy;

	always_ff @(posedge HCLK)
	begin
		if (buffer_take)
		begin
			work_word <= buffer_data;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			busy          <= 1'b0;
			byte_idx      <= 2'd0;
			reset_pending <= 1'b0;
			crc_ff        <= RESET_INIT;
		end
		else
		begin
			if (buffer_take)
			begin
				busy     <= 1'b1;
				byte_idx <= buffer_count;
			end
			else if (busy)
			begin
				crc_ff <= crc_next;
				// Last byte frees the engine
				if (byte_idx == 2'd0)
					busy <= 1'b0;
				else
					byte_idx <= byte_idx - 2'd1;
			end

			if ((reset_chain || reset_pending) && can_load)
			begin
				crc_ff        <= crc_init_out;
				reset_pending <= 1'b0;
			end
			else if (reset_chain)
				reset_pending <= 1'b1;
		end
	end

	// DR reads hold off until the chain has settled
	assign read_wait = buffer_full || busy;

	////////////////////////////////////////
	// Output
	////////////////////////////////////////

	assign crc_masked = crc_ff & width_mask;

	for (genvar i = 0; i < 32; i++)
	begin : g_out_rev
		assign crc_rev[i] = crc_masked[31 - i];
	end

	assign crc_out = rev_out_type ? crc_rev : crc_masked;

endmodule

`default_nettype wire

// ==== source/crc_pkg.sv ====
`default_nettype none

package crc_pkg;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////

	// Word offsets taken from HADDR[4:2]
	localparam logic [2:0] CRC_DR   = 3'h0;
	localparam logic [2:0] CRC_IDR  = 3'h1;
	localparam logic [2:0] CRC_CR   = 3'h2;
	localparam logic [2:0] CRC_INIT = 3'h4;
	localparam logic [2:0] CRC_POL  = 3'h5;

	////////////////////////////////////////
	// Bus encodings
	////////////////////////////////////////

	// AHB transfer types
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// Transfer size, low two bits of HSIZE
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	// Polynomial size, CR[4:3]
	localparam logic [1:0] POLY_32 = 2'd0;
	localparam logic [1:0] POLY_16 = 2'd1;
	localparam logic [1:0] POLY_8  = 2'd2;
	localparam logic [1:0] POLY_7  = 2'd3;

	// Input bit reversal, CR[6:5]
	localparam logic [1:0] REV_NONE = 2'd0;
	localparam logic [1:0] REV_BYTE = 2'd1;
	localparam logic [1:0] REV_HALF = 2'd2;
	localparam logic [1:0] REV_WORD = 2'd3;

	// One DR word, seen whole or as four byte lanes
	typedef union packed {
		logic [31:0] word;
		logic [3:0][7:0] bytes;
	} crc_dr_word_u;

endpackage

`default_nettype wire

// ==== source/host_interface.sv ====
`timescale 1ns/1ns
`default_nettype none

module host_interface
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        HSElx,
	input  wire logic [31:0] HADDR,
	input  wire logic [1:0]  HTRANS,
	input  wire logic [2:0]  HSIZE,
	input  wire logic        HWRITE,
	input  wire logic [31:0] HWDATA,
	input  wire logic        HREADY,
	input  wire logic [31:0] crc_out,
	input  wire logic [31:0] crc_init_out,
	input  wire logic [31:0] crc_poly_out,
	input  wire logic [7:0]  crc_idr_out,
	input  wire logic        buffer_full,
	input  wire logic        reset_pending,
	input  wire logic        read_wait,
	output logic      [31:0] HRDATA,
	output logic             HREADYOUT,
	output logic             HRESP,
	output logic      [31:0] bus_wr,
	output logic      [1:0]  bus_size,
	output logic      [1:0]  rev_in_type,
	output logic             rev_out_type,
	output logic      [1:0]  crc_poly_size,
	output logic             buffer_write_en,
	output logic             crc_init_en,
	output logic             crc_idr_en,
	output logic             crc_poly_en,
	output logic             reset_chain
);

	// Address phase pipeline
	logic [2:0] haddr_pp;
	logic [1:0] hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	// Stored CR fields, bits 7 to 3
	logic [4:0] crc_cr_ff;

	logic sample_bus;
	logic write_en;
	logic read_en;

	// One-hot register selects
	logic dr_sel;
	logic idr_sel;
	logic cr_sel;
	logic init_sel;
	logic poly_sel;

	// Raw requests, before wait-state gating
	logic dr_wr_req;
	logic dr_rd_req;
	logic init_wr_req;
	logic crc_cr_en;
	logic [31:0] crc_cr_rd;

	////////////////////////////////////////
	// Address phase
	////////////////////////////////////////

	// Bus is sampled only when no slave is stretching the data phase
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= crc_pkg::HTRANS_IDLE;
			hwrite_pp <= 1'b0;
			haddr_pp  <= 3'h0;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
			haddr_pp  <= HADDR[4:2];
		end
	end

	// Size only matters for DR writes
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
			hsize_pp <= HSIZE[1:0];
	end

	// SEQ and BUSY are ignored, only NONSEQ acts
	assign write_en = hselx_pp && hwrite_pp && (htrans_pp == crc_pkg::HTRANS_NONSEQ);
	assign read_en  = hselx_pp && !hwrite_pp && (htrans_pp == crc_pkg::HTRANS_NONSEQ);

	// Offset decode
	assign dr_sel   = (haddr_pp == crc_pkg::CRC_DR);
	assign idr_sel  = (haddr_pp == crc_pkg::CRC_IDR);
	assign cr_sel   = (haddr_pp == crc_pkg::CRC_CR);
	assign init_sel = (haddr_pp == crc_pkg::CRC_INIT);
	assign poly_sel = (haddr_pp == crc_pkg::CRC_POL);

	////////////////////////////////////////
	// Data phase
	////////////////////////////////////////

	assign dr_wr_req   = dr_sel && write_en;
	assign dr_rd_req   = dr_sel && read_en;
	assign init_wr_req = init_sel && write_en;

	// Stall while the buffer is busy, a restart is pending or the CRC is not ready
	assign HREADYOUT = !((dr_wr_req && (buffer_full || reset_pending)) ||
	                     (dr_rd_req && read_wait) ||
	                     (init_wr_req && reset_pending));

	// Strobes fire only on the edge that ends the data phase
	assign buffer_write_en = dr_wr_req && HREADYOUT;
	assign crc_init_en     = init_wr_req && HREADYOUT;
	assign crc_idr_en      = idr_sel && write_en;
	assign crc_poly_en     = poly_sel && write_en;
	assign crc_cr_en       = cr_sel && write_en;

	// Write data comes straight from the bus
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// No error responses
	assign HRESP = 1'b0;

	////////////////////////////////////////
	// Control register
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= 5'h00;
		else if (crc_cr_en)
			crc_cr_ff <= HWDATA[7:3];
	end

	// Bit 0 is a self-clearing restart
	assign reset_chain = crc_cr_en && HWDATA[0];

	assign crc_poly_size = crc_cr_ff[1:0];
	assign rev_in_type   = crc_cr_ff[3:2];
	assign rev_out_type  = crc_cr_ff[4];

	////////////////////////////////////////
	// Read data
	////////////////////////////////////////

	assign crc_cr_rd = {24'h0, crc_cr_ff, 3'h0};

	// AND-OR mux over the one-hot selects
	assign HRDATA = ({32{dr_sel}}   & crc_out) |
	                ({32{idr_sel}}  & {24'h0, crc_idr_out}) |
	                ({32{cr_sel}}   & crc_cr_rd) |
	                ({32{init_sel}} & crc_init_out) |
	                ({32{poly_sel}} & crc_poly_out);

endmodule

`default_nettype wire
